// ==== pipelinePkg.sv ====
`default_nettype none

package pipelinePkg;

    // Width of a top or bot function
    localparam int FUNC_WIDTH = 128;

    // Default lane count, each lane checks one slice of the function
    localparam int NUM_LANES = 4;
    localparam int LANE_WIDTH = FUNC_WIDTH / NUM_LANES;

    // A lane count must hold LANE_WIDTH itself, so one bit more than its log
    localparam int COUNT_WIDTH = $clog2(LANE_WIDTH + 1);
    localparam int TOTAL_COUNT_WIDTH = $clog2(FUNC_WIDTH + 1);

    typedef logic [FUNC_WIDTH-1:0] funcT;
    typedef logic [LANE_WIDTH-1:0] sliceT;
    typedef logic [COUNT_WIDTH-1:0] laneCountT;
    typedef logic [TOTAL_COUNT_WIDTH-1:0] totalCountT;

    // Result of one lane for one bot
    typedef struct packed {
        logic isSubset;
        laneCountT bitCount;
    } laneResultT;

    // Combined result of all lanes, isSubset is set only when every lane was a subset
    typedef struct packed {
        logic isSubset;
        totalCountT bitCount;
    } checkResultT;

endpackage

`default_nettype wire

// ==== enabledShiftRegister.sv ====
`default_nettype none

module enabledShiftRegister #(
    parameter int CYCLES = 2,
    parameter int WIDTH = 1,
    parameter logic [WIDTH-1:0] RESET_VALUE = '0
) (
    input  logic clk,
    input  logic rst,
    input  logic enable,
    input  logic [WIDTH-1:0] dataIn,
    output logic [WIDTH-1:0] dataOut
);

    logic [WIDTH-1:0] stages [CYCLES];

    // The whole chain moves by one stage per enabled cycle and holds otherwise
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < CYCLES; i++) begin
                stages[i] <= RESET_VALUE;
            end
        end else if (enable) begin
            stages[0] <= dataIn;
            for (int i = 1; i < CYCLES; i++) begin
                stages[i] <= stages[i-1];
            end
        end
    end

    assign dataOut = stages[CYCLES-1];

endmodule

`default_nettype wire

// ==== botValidTracker.sv ====
`default_nettype none

module botValidTracker #(
    parameter int LANE_DEPTH = 4
) (
    input  logic clk,
    input  logic rst,
    input  logic advance,
    input  logic isBotValid,
    output logic laneOutValid,
    output logic allBotsCleared
);

    localparam int CNT_WIDTH = $clog2(LANE_DEPTH + 1);

    logic lastStageValid;
    logic prevAdvance;
    logic [CNT_WIDTH-1:0] advancesUntilEmpty;

    // Same depth and same enable as the lanes, so the last bit belongs to the lane outputs
    enabledShiftRegister #(
        .CYCLES(LANE_DEPTH),
        .WIDTH(1),
        .RESET_VALUE(1'b0)
    ) validHistory (
        .clk(clk),
        .rst(rst),
        .enable(advance),
        .dataIn(isBotValid),
        .dataOut(lastStageValid)
    );

    // The last stage only holds a new entry in the cycle right after an advance
    always_ff @(posedge clk) begin
        if (rst) begin
            prevAdvance <= 1'b0;
        end else begin
            prevAdvance <= advance;
        end
    end

    assign laneOutValid = lastStageValid & prevAdvance;

    // Counts the advances still needed to push the newest valid bot out of the lanes
    always_ff @(posedge clk) begin
        if (rst) begin
            advancesUntilEmpty <= '0;
            allBotsCleared <= 1'b1;
        end else begin
            if (advance) begin
                if (isBotValid) begin
                    advancesUntilEmpty <= CNT_WIDTH'(LANE_DEPTH);
                end else if (advancesUntilEmpty != '0) begin
                    advancesUntilEmpty <= advancesUntilEmpty - 1'b1;
                end
            end
            // The flag drops as soon as a valid bot enters and rises once the count has run out
            allBotsCleared <= (advancesUntilEmpty == '0) & ~(advance & isBotValid);
        end
    end

endmodule

`default_nettype wire

// ==== pipelineManager.sv ====
`default_nettype none

module pipelineManager #(
    parameter int INIT_ADVANCES = 3
) (
    input  logic clk,
    input  logic rst,
    input  logic topValid,
    input  pipelinePkg::funcT topIn,
    output logic topReady,
    input  logic botValid,
    input  pipelinePkg::funcT botIn,
    output logic botReady,
    input  logic pipelineReady,
    input  logic allBotsCleared,
    output pipelinePkg::funcT topReg,
    output pipelinePkg::funcT bot,
    output logic isBotValid,
    output logic advance
);

    // Signed so the counter can run up from a negative start to zero
    localparam int INDEX_WIDTH = $clog2(INIT_ADVANCES + 1) + 1;
    localparam logic signed [INDEX_WIDTH-1:0] INDEX_START = INDEX_WIDTH'(-INIT_ADVANCES);

    typedef enum logic [1:0] {
        noTop,
        running,
        draining,
        initializing
    } managerStateT;

    managerStateT state;
    pipelinePkg::funcT pendingTop;
    logic signed [INDEX_WIDTH-1:0] botIndex;
    logic topTaken;

    // Draining keeps stepping too, otherwise the old bots would never leave the lanes
    assign advance = pipelineReady & ~rst & (state != noTop);

    assign topReady = (state == noTop) | (state == running);
    assign topTaken = topValid & topReady;

    // Admission happens only here, the lanes accept whatever comes with isBotValid
    assign botReady = advance & (state == running);
    assign isBotValid = botValid & botReady;
    assign bot = botIn;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= noTop;
            botIndex <= '0;
        end else begin
            case (state)
                noTop: begin
                    if (topTaken) begin
                        state <= initializing;
                        botIndex <= INDEX_START;
                    end
                end
                running: begin
                    if (topTaken) begin
                        state <= draining;
                    end
                end
                draining: begin
                    if (allBotsCleared) begin
                        state <= initializing;
                        botIndex <= INDEX_START;
                    end
                end
                initializing: begin
                    // Empty advances flush the old top out of the lane input stages
                    if (advance) begin
                        if (botIndex == '1) begin
                            state <= running;
                        end
                        botIndex <= botIndex + 1'b1;
                    end
                end
                default: begin
                    state <= noTop;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == noTop && topTaken) begin
            topReg <= topIn;
        end else if (state == draining && allBotsCleared) begin
            topReg <= pendingTop;
        end
        // The new top waits here while the bots of the old one finish
        if (state == running && topTaken) begin
            pendingTop <= topIn;
        end
    end

endmodule

`default_nettype wire

// ==== subsetLane.sv ====
`default_nettype none

module subsetLane #(
    parameter int LANE_DEPTH = 4
) (
    input  logic clk,
    input  logic rst,
    input  logic advance,
    input  pipelinePkg::sliceT topSlice,
    input  pipelinePkg::sliceT botSlice,
    output pipelinePkg::laneResultT laneResult
);

    pipelinePkg::sliceT topStage;
    pipelinePkg::sliceT botStage;
    pipelinePkg::laneResultT computed;
    pipelinePkg::laneResultT computedStage;

    function automatic pipelinePkg::laneCountT popCount(input pipelinePkg::sliceT value);
        pipelinePkg::laneCountT total;
        total = '0;
        for (int i = 0; i < pipelinePkg::LANE_WIDTH; i++) begin
            total = total + pipelinePkg::laneCountT'(value[i]);
        end
        return total;
    endfunction

    // Top is captured together with its bot so a later top change cannot reach this bot
    always_ff @(posedge clk) begin
        if (advance) begin
            topStage <= topSlice;
            botStage <= botSlice;
        end
    end

    // A subset has no bot bit where the top bit is clear
    always_comb begin
        computed.isSubset = ~|(botStage & ~topStage);
        computed.bitCount = popCount(botStage);
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            computedStage <= computed;
        end
    end

    // Remaining stages bring the total depth up to LANE_DEPTH
    enabledShiftRegister #(
        .CYCLES(LANE_DEPTH - 2),
        .WIDTH($bits(pipelinePkg::laneResultT)),
        .RESET_VALUE('0)
    ) resultDelay (
        .clk(clk),
        .rst(rst),
        .enable(advance),
        .dataIn(computedStage),
        .dataOut(laneResult)
    );

endmodule

`default_nettype wire

// ==== resultCollector.sv ====
`default_nettype none

module resultCollector #(
    parameter int NUM_LANES = 4,
    parameter int LANE_DEPTH = 4,
    parameter int FIFO_DEPTH = 16
) (
    input  logic clk,
    input  logic rst,
    input  pipelinePkg::laneResultT [NUM_LANES-1:0] laneResults,
    input  logic laneOutValid,
    output pipelinePkg::checkResultT result,
    output logic resultValid,
    input  logic resultReady,
    output logic pipelineReady
);

    localparam int PTR_WIDTH = $clog2(FIFO_DEPTH);
    localparam int CNT_WIDTH = $clog2(FIFO_DEPTH + 1);

    pipelinePkg::checkResultT combined;
    pipelinePkg::checkResultT fifoMem [FIFO_DEPTH];
    logic [PTR_WIDTH-1:0] writePtr;
    logic [PTR_WIDTH-1:0] readPtr;
    logic [CNT_WIDTH-1:0] count;
    logic [CNT_WIDTH-1:0] freeEntries;
    logic doWrite;
    logic doRead;

    // Every lane must agree on the subset flag, the counts simply add up
    always_comb begin
        combined.isSubset = 1'b1;
        combined.bitCount = '0;
        for (int i = 0; i < NUM_LANES; i++) begin
            combined.isSubset = combined.isSubset & laneResults[i].isSubset;
            combined.bitCount = combined.bitCount
                + pipelinePkg::totalCountT'(laneResults[i].bitCount);
        end
    end

    assign doWrite = laneOutValid;
    assign doRead = resultValid & resultReady;

    always_ff @(posedge clk) begin
        if (doWrite) begin
            fifoMem[writePtr] <= combined;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            writePtr <= '0;
            readPtr <= '0;
            count <= '0;
        end else begin
            if (doWrite) begin
                writePtr <= (writePtr == PTR_WIDTH'(FIFO_DEPTH - 1)) ? '0 : writePtr + 1'b1;
            end
            if (doRead) begin
                readPtr <= (readPtr == PTR_WIDTH'(FIFO_DEPTH - 1)) ? '0 : readPtr + 1'b1;
            end
            count <= count + CNT_WIDTH'(doWrite) - CNT_WIDTH'(doRead);
        end
    end

    // Head entry stays put until it is read, so the output holds steady
    assign result = fifoMem[readPtr];
    assign resultValid = (count != '0);

    // Keep room for everything that can still arrive once the lanes stop stepping
    assign freeEntries = CNT_WIDTH'(FIFO_DEPTH) - count;
    assign pipelineReady = freeEntries > CNT_WIDTH'(LANE_DEPTH + 2);

endmodule

`default_nettype wire

// ==== subsetPipelineTop.sv ====
`default_nettype none

module subsetPipelineTop #(
    parameter int NUM_LANES = pipelinePkg::NUM_LANES,
    parameter int LANE_DEPTH = 4,
    parameter int INIT_ADVANCES = 3,
    parameter int FIFO_DEPTH = 16
) (
    input  logic clk,
    input  logic rst,
    input  logic topValid,
    input  pipelinePkg::funcT topIn,
    output logic topReady,
    input  logic botValid,
    input  pipelinePkg::funcT botIn,
    output logic botReady,
    output pipelinePkg::checkResultT result,
    output logic resultValid,
    input  logic resultReady
);

    pipelinePkg::funcT topReg;
    pipelinePkg::funcT bot;
    logic isBotValid;
    logic advance;
    logic pipelineReady;
    logic allBotsCleared;
    logic laneOutValid;
    pipelinePkg::laneResultT [NUM_LANES-1:0] laneResults;

    pipelineManager #(
        .INIT_ADVANCES(INIT_ADVANCES)
    ) manager (
        .clk(clk),
        .rst(rst),
        .topValid(topValid),
        .topIn(topIn),
        .topReady(topReady),
        .botValid(botValid),
        .botIn(botIn),
        .botReady(botReady),
        .pipelineReady(pipelineReady),
        .allBotsCleared(allBotsCleared),
        .topReg(topReg),
        .bot(bot),
        .isBotValid(isBotValid),
        .advance(advance)
    );

    botValidTracker #(
        .LANE_DEPTH(LANE_DEPTH)
    ) tracker (
        .clk(clk),
        .rst(rst),
        .advance(advance),
        .isBotValid(isBotValid),
        .laneOutValid(laneOutValid),
        .allBotsCleared(allBotsCleared)
    );

    // Each lane works on its own slice of top and bot
    for (genvar i = 0; i < NUM_LANES; i++) begin : gLanes
        subsetLane #(
            .LANE_DEPTH(LANE_DEPTH)
        ) lane (
            .clk(clk),
            .rst(rst),
            .advance(advance),
            .topSlice(topReg[i*pipelinePkg::LANE_WIDTH +: pipelinePkg::LANE_WIDTH]),
            .botSlice(bot[i*pipelinePkg::LANE_WIDTH +: pipelinePkg::LANE_WIDTH]),
            .laneResult(laneResults[i])
        );
    end

    resultCollector #(
        .NUM_LANES(NUM_LANES),
        .LANE_DEPTH(LANE_DEPTH),
        .FIFO_DEPTH(FIFO_DEPTH)
    ) collector (
        .clk(clk),
        .rst(rst),
        .laneResults(laneResults),
        .laneOutValid(laneOutValid),
        .result(result),
        .resultValid(resultValid),
        .resultReady(resultReady),
        .pipelineReady(pipelineReady)
    );

endmodule

`default_nettype wire

// ==== tbSubsetPipeline.sv ====
`default_nettype none

module tbSubsetPipeline;

    localparam int PERIOD = 40;
    localparam int DRIVE_DELAY = 1;
    localparam int NUM_LANES = pipelinePkg::NUM_LANES;
    localparam int LANE_DEPTH = 4;
    localparam int INIT_ADVANCES = 3;
    localparam int FIFO_DEPTH = 16;

    localparam int BOTS_RANDOM = 200;
    localparam int BOTS_SWITCH = 30;
    localparam int BOTS_STALL = 100;
    localparam int BOTS_EXTREME = 6;
    localparam int NUM_BOTS = BOTS_RANDOM + 2 * BOTS_SWITCH + BOTS_STALL + BOTS_EXTREME;
    localparam int QUIET_CYCLES = 4 * (LANE_DEPTH + FIFO_DEPTH);

    logic clk;
    logic rst;
    logic topValid;
    pipelinePkg::funcT topIn;
    logic topReady;
    logic botValid;
    pipelinePkg::funcT botIn;
    logic botReady;
    pipelinePkg::checkResultT result;
    logic resultValid;
    logic resultReady;

    integer seed;
    // 0 keeps resultReady high, 1 toggles it at random, 2 holds it in long stretches
    int readyMode;
    int stretchLeft;
    pipelinePkg::funcT currentTop;

    pipelinePkg::checkResultT expectedQ[$];
    pipelinePkg::checkResultT expectedNow;
    pipelinePkg::checkResultT heldResult;
    pipelinePkg::funcT modelTop;
    logic holdPending;
    logic haveTop;
    int lockedCycles;

    subsetPipelineTop #(
        .NUM_LANES(NUM_LANES),
        .LANE_DEPTH(LANE_DEPTH),
        .INIT_ADVANCES(INIT_ADVANCES),
        .FIFO_DEPTH(FIFO_DEPTH)
    ) uut (
        .clk(clk),
        .rst(rst),
        .topValid(topValid),
        .topIn(topIn),
        .topReady(topReady),
        .botValid(botValid),
        .botIn(botIn),
        .botReady(botReady),
        .result(result),
        .resultValid(resultValid),
        .resultReady(resultReady)
    );

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    task automatic stopWithError(input string message);
        $display("%s", message);
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic checkEqual(input string name, input logic [127:0] actual,
                              input logic [127:0] expected);
        if (actual !== expected) begin
            stopWithError($sformatf("mismatch %s: got %0h, expected %0h", name, actual, expected));
        end
    endtask

    // A bot is a subset when none of its bits lies outside the top
    function automatic pipelinePkg::checkResultT expectedFor(input pipelinePkg::funcT top,
                                                            input pipelinePkg::funcT value);
        pipelinePkg::checkResultT r;
        r.isSubset = ((value & ~top) == '0);
        r.bitCount = '0;
        for (int i = 0; i < pipelinePkg::FUNC_WIDTH; i++) begin
            if (value[i]) begin
                r.bitCount = r.bitCount + 1'b1;
            end
        end
        return r;
    endfunction

    function automatic pipelinePkg::funcT randomFunc();
        return {$random(seed), $random(seed), $random(seed), $random(seed)};
    endfunction

    // Half of the bots are the top with bits cleared, so they are always subsets
    function automatic pipelinePkg::funcT makeBot(input pipelinePkg::funcT top);
        logic [31:0] coin;
        coin = $random(seed);
        if (coin[0]) begin
            return top & randomFunc();
        end
        return randomFunc();
    endfunction

    // Moves to just after the next rising edge and updates resultReady there
    task automatic stepCycle();
        logic [31:0] raw;
        @(posedge clk);
        #(DRIVE_DELAY);
        raw = $random(seed);
        if (readyMode == 0) begin
            resultReady = 1'b1;
        end else if (readyMode == 1) begin
            resultReady = raw[0];
        end else if (stretchLeft == 0) begin
            resultReady = ~resultReady;
            stretchLeft = resultReady ? 1 + raw % 20 : 20 + raw % 40;
        end else begin
            stretchLeft--;
        end
    endtask

    task automatic gapCycles(input int maxGap);
        logic [31:0] raw;
        raw = $random(seed);
        repeat (raw % (maxGap + 1)) stepCycle();
    endtask

    task automatic sendBot(input pipelinePkg::funcT value);
        logic taken;
        botValid = 1'b1;
        botIn = value;
        taken = 1'b0;
        while (!taken) begin
            @(negedge clk);
            taken = botReady;
            stepCycle();
        end
        botValid = 1'b0;
    endtask

    task automatic sendTop(input pipelinePkg::funcT value);
        logic taken;
        topValid = 1'b1;
        topIn = value;
        currentTop = value;
        taken = 1'b0;
        while (!taken) begin
            @(negedge clk);
            taken = topReady;
            stepCycle();
        end
        topValid = 1'b0;
    endtask

    task automatic checkIdleCycle();
        @(negedge clk);
        checkEqual("topReady", topReady, 1'b1);
        checkEqual("botReady", botReady, 1'b0);
        checkEqual("resultValid", resultValid, 1'b0);
        stepCycle();
    endtask

    // Monitor samples mid-cycle, when every input and output has settled
    always @(negedge clk) begin
        if (!rst) begin
            if (holdPending) begin
                checkEqual("resultValid", resultValid, 1'b1);
                checkEqual("result", result, heldResult);
            end
            if (resultValid && resultReady) begin
                if (expectedQ.size() == 0) begin
                    stopWithError("A result came out while no bot was waiting for one");
                end else begin
                    expectedNow = expectedQ.pop_front();
                    checkEqual("result", result, expectedNow);
                end
            end
            holdPending = resultValid && !resultReady;
            heldResult = result;
            if (lockedCycles > 0) begin
                checkEqual("botReady", botReady, 1'b0);
                lockedCycles--;
            end
            if (botValid && botReady) begin
                expectedQ.push_back(expectedFor(modelTop, botIn));
            end
            // A top taken while running adds at least one drain cycle before initialization
            if (topValid && topReady) begin
                lockedCycles = INIT_ADVANCES + (haveTop ? 1 : 0);
                haveTop = 1'b1;
                modelTop = topIn;
            end
        end
    end

    initial begin
        #(NUM_BOTS * (LANE_DEPTH + FIFO_DEPTH + 40) * PERIOD);
        stopWithError("Timeout: the run did not finish within the expected time");
    end

    initial begin
        seed = 32;
        readyMode = 0;
        stretchLeft = 0;
        rst = 1'b1;
        topValid = 1'b0;
        topIn = '0;
        botValid = 1'b0;
        botIn = '0;
        resultReady = 1'b1;
        currentTop = '0;
        modelTop = '0;
        holdPending = 1'b0;
        haveTop = 1'b0;
        lockedCycles = 0;

        stepCycle();
        checkIdleCycle();
        rst = 1'b0;
        checkIdleCycle();
        checkIdleCycle();

        readyMode = 1;
        sendTop(randomFunc());
        for (int i = 0; i < BOTS_RANDOM; i++) begin
            sendBot(makeBot(currentTop));
            gapCycles(3);
        end

        // New top while the earlier bots are still in the lanes
        for (int i = 0; i < BOTS_SWITCH; i++) begin
            sendBot(makeBot(currentTop));
            gapCycles(2);
        end
        sendTop(randomFunc());
        for (int i = 0; i < BOTS_SWITCH; i++) begin
            sendBot(makeBot(currentTop));
            gapCycles(2);
        end

        readyMode = 2;
        for (int i = 0; i < BOTS_STALL; i++) begin
            sendBot(makeBot(currentTop));
            gapCycles(1);
        end

        readyMode = 0;
        sendTop('1);
        sendBot('1);
        sendBot('0);
        sendBot(makeBot(currentTop));
        sendTop('0);
        sendBot('1);
        sendBot('0);
        sendBot(randomFunc());

        while (expectedQ.size() != 0) begin
            stepCycle();
        end
        repeat (QUIET_CYCLES) begin
            @(negedge clk);
            checkEqual("resultValid", resultValid, 1'b0);
            stepCycle();
        end

        $display("All tests passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
pipelinePkg.sv
enabledShiftRegister.sv
botValidTracker.sv
pipelineManager.sv
subsetLane.sv
resultCollector.sv
subsetPipelineTop.sv
tbSubsetPipeline.sv
